/* hdl/kw_scan_consts.svh */
`ifndef KW_SCAN_CONSTS_SVH
`define KW_SCAN_CONSTS_SVH

// Stream id width and number of tracked streams
`define KW_SID_W        6
`define KW_NUM_STREAMS  64

// Payload char width
`define KW_CHAR_W       8

// Packet counters wrap at this width
`define KW_CNT_W        16

// Automaton state is a prefix length 0..KW_LEN
`define KW_STATE_W      3
`define KW_LEN          4

// Keywords, first byte in the top byte lane
// "USER"
`define KW_PATTERN_A    32'h5553_4552
// "PASS"
`define KW_PATTERN_B    32'h5041_5353

`endif

/* hdl/kw_scan_pkg.sv */
`include "kw_scan_consts.svh"

package kw_scan_pkg;

  // Packet input strobes and payload
  // Only one of sop, char_vld, eop is high in a cycle
  typedef struct packed
  {
    logic                   sop;
    logic                   char_vld;
    logic                   eop;
    logic [`KW_SID_W-1:0]   stream_id;
    logic [`KW_CHAR_W-1:0]  char_data;
  } pkt_in_t;

  // Sequencer to matcher strobes, shared by both matchers
  typedef struct packed
  {
    // Restore the stream context
    logic                   load_state;
    // Stream id not seen since reset, start from state 0
    logic                   new_stream;
    logic                   char_vld;
    // Packet done, commit count and save context
    logic                   finalize;
    // Held from sop until finalize
    logic [`KW_SID_W-1:0]   stream_id;
    logic [`KW_CHAR_W-1:0]  char_data;
  } match_ctl_t;

  // Sequencer FSM
  typedef enum logic [1:0]
  {
    IDLE   = 2'd0,
    IN_PKT = 2'd1,
    DRAIN  = 2'd2
  } seq_state_e;

endpackage

/* hdl/keyword_dfa.sv */
`timescale 1ns/1ns

`include "kw_scan_consts.svh"

module keyword_dfa #(
  // Keyword bytes, first byte in the top lane
  // Must have no self-overlap for the naive fallback to be exact
  parameter logic [`KW_LEN*`KW_CHAR_W-1:0] pattern = `KW_PATTERN_A
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`KW_CHAR_W-1:0]  char_in,
  input  logic                   char_vld,
  input  logic [`KW_STATE_W-1:0] state_in,
  input  logic                   state_in_vld,
  output logic [`KW_STATE_W-1:0] state_out,
  output logic                   accept
);

  // Index width into the keyword byte table
  localparam int IDX_W = $clog2(`KW_LEN);

  // Full match state and the state after a first-byte hit
  localparam logic [`KW_STATE_W-1:0] ST_FULL = `KW_LEN;
  localparam logic [`KW_STATE_W-1:0] ST_ONE  = 1;

  // Keyword split into bytes, index 0 is the first char
  logic [`KW_CHAR_W-1:0] pat_bytes [`KW_LEN];

  // Current prefix length and registered accept
  logic [`KW_STATE_W-1:0] state_q;
  logic                   accept_q;

  // Next state logic
  logic [`KW_STATE_W-1:0] base;
  logic [`KW_CHAR_W-1:0]  exp_char;
  logic [`KW_STATE_W-1:0] nxt;

  genvar gi;
  generate
    for (gi = 0; gi < `KW_LEN; gi++)
    begin : g_pat
      assign pat_bytes[gi] = pattern[(`KW_LEN-1-gi)*`KW_CHAR_W +: `KW_CHAR_W];
    end
  endgenerate

  always_comb
  begin
    // After a full match start over as from state 0
    base = (state_q == ST_FULL) ? '0 : state_q;
    // Byte that extends the current prefix
    exp_char = pat_bytes[base[IDX_W-1:0]];
    if (char_in == exp_char)
    begin
      nxt = base + 1'b1;
    end
    else if (char_in == pat_bytes[0])
    begin
      // Naive fallback, the char may still open a new match
      nxt = ST_ONE;
    end
    else
    begin
      nxt = '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q  <= '0;
      accept_q <= 1'b0;
    end
    else
    begin
      // accept is a single cycle pulse
      accept_q <= 1'b0;
      // A context load wins over a char in the same cycle
      if (state_in_vld)
      begin
        state_q <= state_in;
      end
      else if (char_vld)
      begin
        state_q  <= nxt;
        accept_q <= (nxt == ST_FULL);
      end
    end
  end

  // Pulses together with the state reaching KW_LEN
  assign state_out = state_q;
  assign accept    = accept_q;

endmodule

/* hdl/stream_matcher.sv */
`timescale 1ns/1ns

`include "kw_scan_consts.svh"

module stream_matcher #(
  parameter logic [`KW_LEN*`KW_CHAR_W-1:0] pattern = `KW_PATTERN_A
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  kw_scan_pkg::match_ctl_t     ctl,
  input  logic [`KW_NUM_STREAMS-1:0]  enable,
  output logic [`KW_CNT_W-1:0]        count,
  output logic                        fired
);

  // Saved automaton state per stream
  logic [`KW_STATE_W-1:0] state_mem [`KW_NUM_STREAMS];

  // Restored state, one cycle after load_state
  logic [`KW_STATE_W-1:0] state_in;
  logic                   state_in_vld;

  // Registered automaton inputs
  logic [`KW_CHAR_W-1:0]  char_in_r;
  logic                   char_vld_r;
  logic [`KW_STATE_W-1:0] state_in_r;
  logic                   state_in_vld_r;

  // Automaton outputs, raw and registered
  logic [`KW_STATE_W-1:0] state_out;
  logic                   accept_out;
  logic [`KW_STATE_W-1:0] state_out_r;
  logic                   accept_out_r;

  // Keyword seen somewhere in the open packet
  logic                   spec_match;
  logic [`KW_CNT_W-1:0]   count_q;

  // Finalize on a stream whose keyword is enabled
  logic                   commit;

  assign commit = ctl.finalize && enable[ctl.stream_id];

  // Context restore, new streams start from the idle state
  always_ff @(posedge clk)
  begin
    if (ctl.load_state)
    begin
      state_in <= ctl.new_stream ? '0 : state_mem[ctl.stream_id];
    end
  end

  // Context save only for enabled streams
  always_ff @(posedge clk)
  begin
    if (commit)
    begin
      state_mem[ctl.stream_id] <= state_out_r;
    end
  end

  // Automaton I/O pipeline, valids and accept are control
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_in_vld   <= 1'b0;
      state_in_vld_r <= 1'b0;
      char_vld_r     <= 1'b0;
      accept_out_r   <= 1'b0;
    end
    else
    begin
      state_in_vld   <= ctl.load_state;
      state_in_vld_r <= state_in_vld;
      char_vld_r     <= ctl.char_vld;
      accept_out_r   <= accept_out;
    end
  end

  // Payload side of the same pipeline
  always_ff @(posedge clk)
  begin
    state_in_r  <= state_in;
    char_in_r   <= ctl.char_data;
    state_out_r <= state_out;
  end

  // Speculative flag and packet count
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      spec_match <= 1'b0;
      count_q    <= '0;
    end
    else
    begin
      // New packet, forget the last result
      if (ctl.load_state)
      begin
        spec_match <= 1'b0;
      end
      if (accept_out_r)
      begin
        spec_match <= 1'b1;
      end
      if (ctl.finalize)
      begin
        if (commit)
        begin
          // Wraps at KW_CNT_W bits
          count_q <= count_q + {{(`KW_CNT_W-1){1'b0}}, spec_match};
        end
        else
        begin
          spec_match <= 1'b0;
        end
      end
    end
  end

  keyword_dfa #(
    .pattern (pattern)
  ) u_dfa (
    .clk          (clk),
    .rst_n        (rst_n),
    .char_in      (char_in_r),
    .char_vld     (char_vld_r),
    .state_in     (state_in_r),
    .state_in_vld (state_in_vld_r),
    .state_out    (state_out),
    .accept       (accept_out)
  );

  assign count = count_q;
  assign fired = spec_match;

endmodule

/* hdl/packet_sequencer.sv */
`timescale 1ns/1ns

`include "kw_scan_consts.svh"

module packet_sequencer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  kw_scan_pkg::pkt_in_t     pkt_in,
  output kw_scan_pkg::match_ctl_t  ctl
);

  import kw_scan_pkg::*;

  // Char delay, keeps chars behind the context restore
  localparam int CHAR_DLY = 3;
  // Cycles from eop to finalize, covers the last accept
  localparam int FIN_DLY  = 6;
  localparam int CNT_W    = $clog2(FIN_DLY);

  seq_state_e state_q;

  // Stream id of the open packet
  logic [`KW_SID_W-1:0]      sid_q;
  logic                      load_q;
  logic                      new_q;
  logic                      fin_q;
  logic [CNT_W-1:0]          drain_cnt;

  // One bit per stream id, set at its first sop
  logic [`KW_NUM_STREAMS-1:0] seen_map;

  // Char delay line
  logic [CHAR_DLY-1:0]       vld_pipe;
  logic [`KW_CHAR_W-1:0]     char_pipe [CHAR_DLY];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q   <= IDLE;
      sid_q     <= '0;
      load_q    <= 1'b0;
      new_q     <= 1'b0;
      fin_q     <= 1'b0;
      drain_cnt <= '0;
      seen_map  <= '0;
      vld_pipe  <= '0;
    end
    else
    begin
      load_q <= 1'b0;
      new_q  <= 1'b0;
      fin_q  <= 1'b0;
      // Chars only count inside a packet
      vld_pipe <= {vld_pipe[CHAR_DLY-2:0], pkt_in.char_vld && (state_q == IN_PKT)};
      case (state_q)
        IDLE:
        begin
          if (pkt_in.sop)
          begin
            sid_q    <= pkt_in.stream_id;
            load_q   <= 1'b1;
            new_q    <= ~seen_map[pkt_in.stream_id];
            seen_map[pkt_in.stream_id] <= 1'b1;
            state_q  <= IN_PKT;
          end
        end
        IN_PKT:
        begin
          if (pkt_in.eop)
          begin
            drain_cnt <= CNT_W'(FIN_DLY - 1);
            state_q   <= DRAIN;
          end
        end
        DRAIN:
        begin
          // Last count step issues finalize
          if (drain_cnt == CNT_W'(1))
          begin
            fin_q   <= 1'b1;
            state_q <= IDLE;
          end
          else
          begin
            drain_cnt <= drain_cnt - 1'b1;
          end
        end
        default:
        begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // Char payload shifts along with its valid bit
  always_ff @(posedge clk)
  begin
    char_pipe[0] <= pkt_in.char_data;
    for (int i = 1; i < CHAR_DLY; i++)
    begin
      char_pipe[i] <= char_pipe[i-1];
    end
  end

  assign ctl.load_state = load_q;
  assign ctl.new_stream = new_q;
  assign ctl.char_vld   = vld_pipe[CHAR_DLY-1];
  assign ctl.finalize   = fin_q;
  assign ctl.stream_id  = sid_q;
  assign ctl.char_data  = char_pipe[CHAR_DLY-1];

endmodule

/* hdl/kw_scan_top.sv */
`timescale 1ns/1ns

`include "kw_scan_consts.svh"

module kw_scan_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  kw_scan_pkg::pkt_in_t        pkt_in,
  input  logic [`KW_NUM_STREAMS-1:0]  enable_a,
  input  logic [`KW_NUM_STREAMS-1:0]  enable_b,
  output logic [`KW_CNT_W-1:0]        count_a,
  output logic [`KW_CNT_W-1:0]        count_b,
  output logic                        fired_a,
  output logic                        fired_b
);

  import kw_scan_pkg::*;

  // Shared strobes to both matchers
  match_ctl_t ctl;

  packet_sequencer u_seq (
    .clk    (clk),
    .rst_n  (rst_n),
    .pkt_in (pkt_in),
    .ctl    (ctl)
  );

  // Keyword A, "USER"
  stream_matcher #(
    .pattern (`KW_PATTERN_A)
  ) u_match_a (
    .clk    (clk),
    .rst_n  (rst_n),
    .ctl    (ctl),
    .enable (enable_a),
    .count  (count_a),
    .fired  (fired_a)
  );

  // Keyword B, "PASS"
  stream_matcher #(
    .pattern (`KW_PATTERN_B)
  ) u_match_b (
    .clk    (clk),
    .rst_n  (rst_n),
    .ctl    (ctl),
    .enable (enable_b),
    .count  (count_b),
    .fired  (fired_b)
  );

endmodule

/* verif/tb_kw_scan.sv */
`timescale 1ns/1ns

`include "kw_scan_consts.svh"

module tb_kw_scan;

  import kw_scan_pkg::*;

  localparam int NUM_RND  = 200;
  // Directed phase has 8 packets carrying 22 chars in total
  localparam int DIR_PKTS = 8;
  localparam int DIR_LEN  = 22 + 2 * DIR_PKTS;
  localparam logic [`KW_STATE_W-1:0] FULL_ST = `KW_LEN;

  logic clk, rst_n, fired_a, fired_b;
  pkt_in_t pkt_in;
  logic [`KW_NUM_STREAMS-1:0] enable_a, enable_b;
  logic [`KW_CNT_W-1:0] count_a, count_b;

  // Reference model keeps a saved prefix per keyword and stream
  // The seen flag is shared by both keywords
  logic [`KW_STATE_W-1:0] saved_a [`KW_NUM_STREAMS];
  logic [`KW_STATE_W-1:0] saved_b [`KW_NUM_STREAMS];
  logic seen [`KW_NUM_STREAMS];
  logic [`KW_CHAR_W-1:0] payload [$];
  // Model hit per char, count step and disabled flag per packet
  logic hit_a, hit_b, dis_a, dis_b;
  logic [`KW_CNT_W-1:0] add_a, add_b;
  // Model results moved to the DUT's output timing
  logic sop_d;
  logic [5:0] eop_pipe, hit_a_pipe, hit_b_pipe;
  logic [`KW_CNT_W-1:0] exp_count_a, exp_count_b;
  logic exp_fired_a, exp_fired_b;

  int cnt_errs, fired_errs, cycle_cnt, limit, total_len;
  int rnd_len [NUM_RND];

  kw_scan_top uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .pkt_in   (pkt_in),
    .enable_a (enable_a),
    .enable_b (enable_b),
    .count_a  (count_a),
    .count_b  (count_b),
    .fired_a  (fired_a),
    .fired_b  (fired_b)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic pkt_in_t make_pkt(input logic sop, input logic vld, input logic eop,
                                       input logic [`KW_SID_W-1:0] sid,
                                       input logic [`KW_CHAR_W-1:0] ch);
    return '{sop: sop, char_vld: vld, eop: eop, stream_id: sid, char_data: ch};
  endfunction

  // Naive keyword automaton over prefix lengths 0..KW_LEN
  function automatic logic [`KW_STATE_W-1:0] next_prefix(input logic [`KW_STATE_W-1:0] cur,
      input logic [`KW_CHAR_W-1:0] ch, input logic [`KW_LEN*`KW_CHAR_W-1:0] pat);
    logic [`KW_STATE_W-1:0] base;
    // After a full match the next char starts over
    base = (cur == FULL_ST) ? '0 : cur;
    if (ch == pat[(`KW_LEN - 1 - base) * `KW_CHAR_W +: `KW_CHAR_W])
      return base + 1'b1;
    if (ch == pat[(`KW_LEN - 1) * `KW_CHAR_W +: `KW_CHAR_W])
      return 1;
    return '0;
  endfunction

  // Finalize of a disabled stream wins, then a hit, then the load clear
  function automatic logic next_fired(input logic cur, input logic clr_load,
                                      input logic set, input logic clr_fin);
    if (clr_fin)
      return 1'b0;
    if (set)
      return 1'b1;
    return clr_load ? 1'b0 : cur;
  endfunction

  // Mostly keyword letters so that matches and near misses are common
  function automatic logic [`KW_CHAR_W-1:0] rand_char();
    string letters;
    int r;
    letters = "USERPA";
    r = $urandom_range(7, 0);
    if (r < 6)
      return letters[r];
    return 8'($urandom);
  endfunction

  task automatic load_text(input string s);
    payload.delete();
    for (int i = 0; i < s.len(); i++)
      payload.push_back(s[i]);
  endtask

  // Drives one packet from payload while the model follows each char
  task automatic send_packet(input logic [`KW_SID_W-1:0] sid,
                             input logic [`KW_NUM_STREAMS-1:0] mask_a,
                             input logic [`KW_NUM_STREAMS-1:0] mask_b);
    logic [`KW_STATE_W-1:0] pa, pb;
    logic spec_a, spec_b;
    // New streams start from prefix 0
    pa = seen[sid] ? saved_a[sid] : '0;
    pb = seen[sid] ? saved_b[sid] : '0;
    spec_a = 1'b0;
    spec_b = 1'b0;
    seen[sid] = 1'b1;
    @(posedge clk);
    enable_a <= mask_a;
    enable_b <= mask_b;
    @(posedge clk);
    pkt_in <= make_pkt(1'b1, 1'b0, 1'b0, sid, '0);
    foreach (payload[i])
    begin
      @(posedge clk);
      pa = next_prefix(pa, payload[i], `KW_PATTERN_A);
      pb = next_prefix(pb, payload[i], `KW_PATTERN_B);
      spec_a |= (pa == FULL_ST);
      spec_b |= (pb == FULL_ST);
      hit_a <= (pa == FULL_ST);
      hit_b <= (pb == FULL_ST);
      pkt_in <= make_pkt(1'b0, 1'b1, 1'b0, sid, payload[i]);
    end
    @(posedge clk);
    pkt_in <= make_pkt(1'b0, 1'b0, 1'b1, sid, '0);
    hit_a <= 1'b0;
    hit_b <= 1'b0;
    add_a <= (mask_a[sid] && spec_a) ? 1 : 0;
    add_b <= (mask_b[sid] && spec_b) ? 1 : 0;
    dis_a <= !mask_a[sid];
    dis_b <= !mask_b[sid];
    // Only enabled streams keep their final prefix
    if (mask_a[sid])
      saved_a[sid] = pa;
    if (mask_b[sid])
      saved_b[sid] = pb;
    @(posedge clk);
    pkt_in <= '0;
    // Finalize comes 6 cycles after eop and count one later
    // Masks stay frozen till then
    repeat (7) @(posedge clk);
  endtask

  // Expected outputs delayed to where the DUT shows them
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      sop_d <= 1'b0;
      eop_pipe <= '0;
      hit_a_pipe <= '0;
      hit_b_pipe <= '0;
      exp_count_a <= '0;
      exp_count_b <= '0;
      exp_fired_a <= 1'b0;
      exp_fired_b <= 1'b0;
    end
    else
    begin
      sop_d <= pkt_in.sop;
      eop_pipe <= {eop_pipe[4:0], pkt_in.eop};
      hit_a_pipe <= {hit_a_pipe[4:0], hit_a};
      hit_b_pipe <= {hit_b_pipe[4:0], hit_b};
      if (eop_pipe[5])
      begin
        exp_count_a <= exp_count_a + add_a;
        exp_count_b <= exp_count_b + add_b;
      end
      exp_fired_a <= next_fired(exp_fired_a, sop_d, hit_a_pipe[5], eop_pipe[5] && dis_a);
      exp_fired_b <= next_fired(exp_fired_b, sop_d, hit_b_pipe[5], eop_pipe[5] && dis_b);
    end
  end

  count_a_check: assert property (@(posedge clk) disable iff (!rst_n) count_a == exp_count_a)
    else
    begin
      cnt_errs++;
      $display("error: count_a is %h, expected %h", $sampled(count_a), $sampled(exp_count_a));
    end
  count_b_check: assert property (@(posedge clk) disable iff (!rst_n) count_b == exp_count_b)
    else
    begin
      cnt_errs++;
      $display("error: count_b is %h, expected %h", $sampled(count_b), $sampled(exp_count_b));
    end
  fired_a_check: assert property (@(posedge clk) disable iff (!rst_n) fired_a == exp_fired_a)
    else
    begin
      fired_errs++;
      $display("error: fired_a is %h, expected %h", $sampled(fired_a), $sampled(exp_fired_a));
    end
  fired_b_check: assert property (@(posedge clk) disable iff (!rst_n) fired_b == exp_fired_b)
    else
    begin
      fired_errs++;
      $display("error: fired_b is %h, expected %h", $sampled(fired_b), $sampled(exp_fired_b));
    end

  // Watchdog
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= limit)
    begin
      $display("Timeout: test did not finish within %0d cycles", limit);
      $display("TB FAILED");
      $finish;
    end
  end

  initial
  begin
    logic [`KW_SID_W-1:0] sid;
    logic [`KW_NUM_STREAMS-1:0] ma, mb;
    void'($urandom(51));
    rst_n = 1'b0;
    pkt_in = '0;
    enable_a = '0;
    enable_b = '0;
    {hit_a, hit_b, dis_a, dis_b, add_a, add_b} = '0;
    cnt_errs = 0;
    fired_errs = 0;
    cycle_cnt = 0;
    for (int i = 0; i < `KW_NUM_STREAMS; i++)
    begin
      seen[i] = 1'b0;
      saved_a[i] = '0;
      saved_b[i] = '0;
    end
    // Budget of 4 cycles per packet cycle with sop and eop included
    total_len = DIR_LEN;
    for (int p = 0; p < NUM_RND; p++)
    begin
      rnd_len[p] = $urandom_range(12, 0);
      total_len += rnd_len[p] + 2;
    end
    limit = 4 * total_len + 10 * (DIR_PKTS + NUM_RND) + 200;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    // Counts and fired flags stay low in the quiet period
    repeat (10) @(posedge clk);
    // USER in one packet on a new stream
    load_text("xUSERx");
    send_packet(6'd1, '1, '1);
    // PASS split over two packets of stream 2 with stream 3 in between
    load_text("PA");
    send_packet(6'd2, '1, '1);
    load_text("QQQ");
    send_packet(6'd3, '1, '1);
    load_text("SS");
    send_packet(6'd2, '1, '1);
    // Stream 4 saves prefix 3 of PASS while enabled
    load_text("PAS");
    send_packet(6'd4, '1, '1);
    // The disabled split leaves prefix 3 in place and SS completes on its first S
    load_text("PA");
    send_packet(6'd4, '1, ~(64'd1 << 4));
    load_text("AB");
    send_packet(6'd3, '1, '1);
    load_text("SS");
    send_packet(6'd4, '1, ~(64'd1 << 4));
    // Random traffic over streams 8 to 15
    for (int p = 0; p < NUM_RND; p++)
    begin
      sid = 6'd8 + 6'($urandom_range(7, 0));
      ma = {$urandom, $urandom} | {$urandom, $urandom};
      mb = {$urandom, $urandom} | {$urandom, $urandom};
      // First packet of a stream is enabled so that a saved context exists later
      if (!seen[sid])
      begin
        ma[sid] = 1'b1;
        mb[sid] = 1'b1;
      end
      payload.delete();
      for (int i = 0; i < rnd_len[p]; i++)
        payload.push_back(rand_char());
      send_packet(sid, ma, mb);
      repeat ($urandom_range(5, 0)) @(posedge clk);
    end
    repeat (10) @(posedge clk);
    $display("Summary: count mismatches %0d, fired mismatches %0d", cnt_errs, fired_errs);
    if (cnt_errs + fired_errs == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+hdl
hdl/kw_scan_pkg.sv
hdl/keyword_dfa.sv
hdl/stream_matcher.sv
hdl/packet_sequencer.sv
hdl/kw_scan_top.sv
verif/tb_kw_scan.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_kw_scan
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
